/* pu.f */
source/pu_pkg.sv
source/pu_io_if.sv
source/pu_pio.sv
source/pu_table_mem.sv
source/pu_io_arb.sv
source/pu_core.sv
source/pu.sv
test/tb_pu.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and scans the log for failure.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_pu -Mdir obj_dir -o tb_pu_sim -f pu.f \
    && ./obj_dir/tb_pu_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or run of tb_pu did not complete"; exit 1; }
cat sim.log
grep -q "sim failed" sim.log && exit 1 || exit 0

/* test/tb_pu.sv */
/*
 * Testbench of the processing-unit cluster.
 * Builds a table of PIO writes, reads and descriptors from an LFSR and a
 * model of both tables, applies it in order and checks PIO data and egress.
 */
module tb_pu import pu_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    typedef enum logic [1:0] {OP_WR, OP_RD, OP_DESC, OP_WAIT} op_t;

    typedef struct packed {
        op_t       op;
        pio_word_t addr;      // PIO address, or the pid of a descriptor.
        pio_word_t data;      // Write data, or the descriptor word.
        pio_word_t exp;       // Read data, or the egress packet data.
        port_id_t  exp_port;
    } row_t;

    localparam int NUM_ENTRIES = 8;
    localparam int ACK_LIMIT   = 8;

    logic                  clk;
    logic                  rst_n;
    logic                  pio_start;
    logic                  pio_rw;
    pio_word_t             pio_addr_wdata;
    logic                  pio_ack;
    logic                  pio_rvalid;
    pio_word_t             pio_rdata;
    logic                  piarb_pu_valid;
    pu_id_t                piarb_pu_pid;
    logic [DATA_NBITS-1:0] piarb_pu_data;
    logic                  pu_em_data_valid;
    port_id_t              pu_em_port_id;
    logic [DATA_NBITS-1:0] pu_em_packet_data;
    pu_id_t                pu_id;

    row_t                  rows [$];
    string                 names [$];
    tbl_word_t             ctx_model [TBL_DEPTH];
    tbl_word_t             sw_model [TBL_DEPTH];
    logic [31:0]           lfsr_state;
    logic [DATA_NBITS-1:0] exp_data [NUM_OF_PU];
    port_id_t              exp_port [NUM_OF_PU];
    string                 exp_name [NUM_OF_PU];
    int                    sent_count [NUM_OF_PU];
    int                    seen_count [NUM_OF_PU];
    int                    pio_errors;
    int                    egress_errors;
    int                    cycles;
    int                    cycle_limit;

    pu i_dut (
        .clk               (clk),
        .rst_n             (rst_n),
        .pio_start         (pio_start),
        .pio_rw            (pio_rw),
        .pio_addr_wdata    (pio_addr_wdata),
        .pio_ack           (pio_ack),
        .pio_rvalid        (pio_rvalid),
        .pio_rdata         (pio_rdata),
        .piarb_pu_valid    (piarb_pu_valid),
        .piarb_pu_pid      (piarb_pu_pid),
        .piarb_pu_data     (piarb_pu_data),
        .pu_em_data_valid  (pu_em_data_valid),
        .pu_em_port_id     (pu_em_port_id),
        .pu_em_packet_data (pu_em_packet_data),
        .pu_id             (pu_id)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles.", cycle_limit);
            $display("sim failed");
            $finish;
        end
    end

    // Egress words are matched to the outstanding descriptor of their core.
    always @(negedge clk) begin
        if (rst_n && pu_em_data_valid) begin
            assert (seen_count[pu_id] < sent_count[pu_id]) else begin
                egress_errors++;
                $display("An egress word from core %0d came with none outstanding.", pu_id);
            end
            if (seen_count[pu_id] < sent_count[pu_id]) begin
                assert (pu_em_packet_data == exp_data[pu_id]) else begin
                    egress_errors++;
                    $display("ERROR %s packet data: expected %h, actual %h",
                             exp_name[pu_id], exp_data[pu_id], pu_em_packet_data);
                end
                assert (pu_em_port_id == exp_port[pu_id]) else begin
                    egress_errors++;
                    $display("ERROR %s port id: expected %h, actual %h",
                             exp_name[pu_id], exp_port[pu_id], pu_em_port_id);
                end
                seen_count[pu_id]++;
            end
        end
    end

    // The Galois LFSR takes one step for each bit handed out.
    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] r;
        logic        b;
        r = '0;
        for (int i = 0; i < n; i++) begin
            b          = lfsr_state[0];
            lfsr_state = (lfsr_state >> 1) ^ (b ? 32'h80200003 : 32'h0);
            r          = {r[30:0], b};
        end
        return r;
    endfunction

    function automatic pio_word_t pio_addr(input tbl_sel_t sel, input tbl_idx_t idx);
        return (pio_word_t'(sel) << 8) | pio_word_t'(idx);
    endfunction

    function automatic logic egress_pending();
        logic p;
        p = 1'b0;
        for (int k = 0; k < NUM_OF_PU; k++) begin
            p = p | (seen_count[k] != sent_count[k]);
        end
        return p;
    endfunction

    task automatic add_row(input op_t op, input string name, input pio_word_t addr,
                           input pio_word_t data, input pio_word_t exp, input port_id_t port);
        row_t r;
        r.op       = op;
        r.addr     = addr;
        r.data     = data;
        r.exp      = exp;
        r.exp_port = port;
        rows.push_back(r);
        names.push_back(name);
    endtask

    // The egress word takes the tag from bits 31:8, the context low byte
    // and switch info bits 3:0.
    task automatic add_desc(input int pid, input string name);
        tbl_idx_t  idx;
        pio_word_t desc;
        idx  = tbl_idx_t'(9 * random_bits(3));
        desc = (random_bits(26) << 6) | pio_word_t'(idx);
        add_row(OP_DESC, name, pio_word_t'(pid), desc,
                {desc[31:8], ctx_model[idx][7:0]}, sw_model[idx][3:0]);
    endtask

    task automatic build_rows();
        tbl_idx_t  idx;
        tbl_word_t w;
        for (int k = 0; k < NUM_ENTRIES; k++) begin
            idx = tbl_idx_t'(k * 9);
            w   = random_bits(32);
            ctx_model[idx] = w;
            add_row(OP_WR, $sformatf("ctx_wr_%0d", idx), pio_addr(TBL_CONN_CONTEXT, idx), w, 0, 0);
            w   = random_bits(32);
            sw_model[idx] = w;
            add_row(OP_WR, $sformatf("sw_wr_%0d", idx), pio_addr(TBL_SWITCH_INFO, idx), w, 0, 0);
        end
        for (int k = 0; k < NUM_ENTRIES; k++) begin
            idx = tbl_idx_t'(k * 9);
            add_row(OP_RD, $sformatf("ctx_rd_%0d", idx), pio_addr(TBL_CONN_CONTEXT, idx), 0,
                    ctx_model[idx], 0);
            add_row(OP_RD, $sformatf("sw_rd_%0d", idx), pio_addr(TBL_SWITCH_INFO, idx), 0,
                    sw_model[idx], 0);
        end
        add_row(OP_WR, "unmapped_wr_2", pio_addr(2'd2, 6'd9), random_bits(32), 0, 0);
        add_row(OP_WR, "unmapped_wr_3", pio_addr(2'd3, 6'd18), random_bits(32), 0, 0);
        add_row(OP_RD, "unmapped_rd_2", pio_addr(2'd2, 6'd9), 0, 0, 0);
        add_row(OP_RD, "unmapped_rd_3", pio_addr(2'd3, 6'd18), 0, 0, 0);
        add_row(OP_RD, "ctx_keep_9", pio_addr(TBL_CONN_CONTEXT, 6'd9), 0, ctx_model[9], 0);
        add_row(OP_RD, "sw_keep_9", pio_addr(TBL_SWITCH_INFO, 6'd9), 0, sw_model[9], 0);
        add_row(OP_RD, "ctx_keep_18", pio_addr(TBL_CONN_CONTEXT, 6'd18), 0, ctx_model[18], 0);
        add_row(OP_RD, "sw_keep_18", pio_addr(TBL_SWITCH_INFO, 6'd18), 0, sw_model[18], 0);
        for (int k = 0; k < NUM_OF_PU; k++) begin
            add_desc(k, $sformatf("single_core%0d", k));
            add_row(OP_WAIT, "wait", 0, 0, 0, 0);
        end
        // With a single pid bus a pair goes out on back-to-back cycles.
        for (int k = 0; k < 3; k++) begin
            add_desc(k % 2, $sformatf("pair%0d_first", k));
            add_desc(1 - k % 2, $sformatf("pair%0d_second", k));
            add_row(OP_WAIT, "wait", 0, 0, 0, 0);
        end
    endtask

    // Inputs change 2 ns after the rising edge and strobes last one cycle.
    task automatic next_slot();
        @(posedge clk);
        #2;
        pio_start      = 1'b0;
        piarb_pu_valid = 1'b0;
    endtask

    task automatic check_idle();
        assert (!pio_ack && !pio_rvalid && !pu_em_data_valid) else begin
            pio_errors++;
            $display("An output strobe went high before any stimulus.");
        end
    endtask

    task automatic pio_write(input string name, input pio_word_t addr, input pio_word_t data);
        int n;
        next_slot();
        pio_start      = 1'b1;
        pio_rw         = 1'b0;
        pio_addr_wdata = addr;
        next_slot();
        pio_addr_wdata = data;
        n = 0;
        @(negedge clk);
        while (!pio_ack && n < ACK_LIMIT) begin
            @(negedge clk);
            n++;
        end
        assert (pio_ack) else begin
            pio_errors++;
            $display("No pio_ack came back for the write to address %h.", addr);
        end
        if (pio_ack) begin
            assert (n == 1) else begin
                pio_errors++;
                $display("ERROR %s ack latency: expected 1, actual %0d", name, n);
            end
        end
    endtask

    task automatic pio_read(input string name, input pio_word_t addr, input pio_word_t exp);
        int lat;
        next_slot();
        pio_start      = 1'b1;
        pio_rw         = 1'b1;
        pio_addr_wdata = addr;
        next_slot();
        lat = 1;
        @(negedge clk);
        while (!pio_rvalid && lat < ACK_LIMIT) begin
            @(negedge clk);
            lat++;
        end
        assert (pio_rvalid) else begin
            pio_errors++;
            $display("No pio_rvalid came back for the read of address %h.", addr);
        end
        if (pio_rvalid) begin
            assert (lat == 2) else begin
                pio_errors++;
                $display("ERROR %s latency: expected 2, actual %0d", name, lat);
            end
            assert (pio_rdata == exp) else begin
                pio_errors++;
                $display("ERROR %s: expected %h, actual %h", name, exp, pio_rdata);
            end
        end
    endtask

    task automatic send_desc(input int i);
        int id;
        id = int'(rows[i].addr);
        next_slot();
        piarb_pu_valid = 1'b1;
        piarb_pu_pid   = pu_id_t'(id);
        piarb_pu_data  = rows[i].data;
        exp_data[id]   = rows[i].exp;
        exp_port[id]   = rows[i].exp_port;
        exp_name[id]   = names[i];
        sent_count[id]++;
    endtask

    task automatic wait_egress();
        next_slot();
        while (egress_pending()) begin
            @(posedge clk);
        end
    endtask

    initial begin
        rst_n          = 1'b0;
        pio_start      = 1'b0;
        pio_rw         = 1'b0;
        pio_addr_wdata = '0;
        piarb_pu_valid = 1'b0;
        piarb_pu_pid   = '0;
        piarb_pu_data  = '0;
        lfsr_state     = 32'h1e2eab24;
        build_rows();
        cycle_limit = rows.size() * 20 + 200;
        repeat (16) begin
            @(negedge clk);
            check_idle();
        end
        @(posedge clk);
        #2;
        rst_n = 1'b1;
        repeat (4) begin
            @(negedge clk);
            check_idle();
        end
        foreach (rows[i]) begin
            case (rows[i].op)
                OP_WR:   pio_write(names[i], rows[i].addr, rows[i].data);
                OP_RD:   pio_read(names[i], rows[i].addr, rows[i].exp);
                OP_DESC: send_desc(i);
                default: wait_egress();
            endcase
        end
        next_slot();
        repeat (10) @(posedge clk);  // Late or doubled egress words show up here.
        $display("Errors: %0d on PIO, %0d on egress.", pio_errors, egress_errors);
        if (pio_errors + egress_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* source/pu.sv */
/*
 * Top level of the processing-unit cluster.
 * Connects the PIO decoder, the two tables, the table-access arbiter and
 * the chain of cores. Core 0 drives the egress outputs.
 */
module pu import pu_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  pio_start,
    input  logic                  pio_rw,
    input  pio_word_t             pio_addr_wdata,
    output logic                  pio_ack,
    output logic                  pio_rvalid,
    output pio_word_t             pio_rdata,
    input  logic                  piarb_pu_valid,
    input  pu_id_t                piarb_pu_pid,
    input  logic [DATA_NBITS-1:0] piarb_pu_data,
    output logic                  pu_em_data_valid,
    output port_id_t              pu_em_port_id,
    output logic [DATA_NBITS-1:0] pu_em_packet_data,
    output pu_id_t                pu_id
);

    logic      reg_wr;
    logic      reg_rd;
    tbl_idx_t  reg_addr;
    tbl_word_t reg_din;
    logic      reg_ms_conn_context;
    logic      reg_ms_switch_info;
    tbl_word_t conn_context_rdata;
    tbl_word_t switch_info_rdata;
    logic      mem_rd_ctx;
    logic      mem_rd_sw;
    tbl_idx_t  mem_addr;
    tbl_word_t ctx_rdata;
    tbl_word_t sw_rdata;

    // Egress chain, index k is the output of core k.
    logic [NUM_OF_PU:0]    em_valid;
    port_id_t              em_port_id [NUM_OF_PU+1];
    logic [DATA_NBITS-1:0] em_data    [NUM_OF_PU+1];
    pu_id_t                em_pu_id   [NUM_OF_PU+1];

    pu_io_if core_io [NUM_OF_PU] ();

    pu_pio u_pu_pio (
        .clk                 (clk),
        .rst_n               (rst_n),
        .pio_start           (pio_start),
        .pio_rw              (pio_rw),
        .pio_addr_wdata      (pio_addr_wdata),
        .reg_wr              (reg_wr),
        .reg_rd              (reg_rd),
        .reg_addr            (reg_addr),
        .reg_din             (reg_din),
        .reg_ms_conn_context (reg_ms_conn_context),
        .reg_ms_switch_info  (reg_ms_switch_info),
        .conn_context_rdata  (conn_context_rdata),
        .switch_info_rdata   (switch_info_rdata),
        .pio_ack             (pio_ack),
        .pio_rvalid          (pio_rvalid),
        .pio_rdata           (pio_rdata)
    );

    pu_table_mem u_conn_context_mem (
        .clk       (clk),
        .rst_n     (rst_n),
        .reg_ms    (reg_ms_conn_context),
        .reg_wr    (reg_wr),
        .reg_rd    (reg_rd),
        .reg_addr  (reg_addr),
        .reg_din   (reg_din),
        .reg_rdata (conn_context_rdata),
        .mem_rd    (mem_rd_ctx),
        .mem_addr  (mem_addr),
        .mem_rdata (ctx_rdata)
    );

    pu_table_mem u_switch_info_mem (
        .clk       (clk),
        .rst_n     (rst_n),
        .reg_ms    (reg_ms_switch_info),
        .reg_wr    (reg_wr),
        .reg_rd    (reg_rd),
        .reg_addr  (reg_addr),
        .reg_din   (reg_din),
        .reg_rdata (switch_info_rdata),
        .mem_rd    (mem_rd_sw),
        .mem_addr  (mem_addr),
        .mem_rdata (sw_rdata)
    );

    pu_io_arb u_pu_io_arb (
        .clk        (clk),
        .rst_n      (rst_n),
        .core_io    (core_io),
        .mem_rd_ctx (mem_rd_ctx),
        .mem_rd_sw  (mem_rd_sw),
        .mem_addr   (mem_addr),
        .ctx_rdata  (ctx_rdata),
        .sw_rdata   (sw_rdata)
    );

    assign em_valid[NUM_OF_PU]   = 1'b0;  // Nothing feeds the last core.
    assign em_port_id[NUM_OF_PU] = '0;
    assign em_data[NUM_OF_PU]    = '0;
    assign em_pu_id[NUM_OF_PU]   = '0;

    for (genvar k = 0; k < NUM_OF_PU; k++) begin : g_core
        pu_core #(
            .PU_ID (pu_id_t'(k))
        ) u_pu_core (
            .clk                   (clk),
            .rst_n                 (rst_n),
            .piarb_pu_valid        (piarb_pu_valid),
            .piarb_pu_pid          (piarb_pu_pid),
            .piarb_pu_data         (piarb_pu_data),
            .io                    (core_io[k]),
            .pu_em_data_valid_in   (em_valid[k+1]),
            .pu_em_port_id_in      (em_port_id[k+1]),
            .pu_em_packet_data_in  (em_data[k+1]),
            .pu_id_in              (em_pu_id[k+1]),
            .pu_em_data_valid_out  (em_valid[k]),
            .pu_em_port_id_out     (em_port_id[k]),
            .pu_em_packet_data_out (em_data[k]),
            .pu_id_out             (em_pu_id[k])
        );
    end

    assign pu_em_data_valid  = em_valid[0];
    assign pu_em_port_id     = em_port_id[0];
    assign pu_em_packet_data = em_data[0];
    assign pu_id             = em_pu_id[0];

endmodule

/* source/pu_core.sv */
/*
 * Packet core. Takes a descriptor addressed to PU_ID, looks up the
 * connection context and switch info entries of its flow, and puts the
 * rewritten word on the egress chain in the first idle chain cycle.
 */
module pu_core import pu_pkg::*; #(
    parameter pu_id_t PU_ID = '0
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  piarb_pu_valid,
    input  pu_id_t                piarb_pu_pid,
    input  logic [DATA_NBITS-1:0] piarb_pu_data,
    pu_io_if.core                 io,
    input  logic                  pu_em_data_valid_in,
    input  port_id_t              pu_em_port_id_in,
    input  logic [DATA_NBITS-1:0] pu_em_packet_data_in,
    input  pu_id_t                pu_id_in,
    output logic                  pu_em_data_valid_out,
    output port_id_t              pu_em_port_id_out,
    output logic [DATA_NBITS-1:0] pu_em_packet_data_out,
    output pu_id_t                pu_id_out
);

    core_state_t               state;
    tbl_idx_t                  flow_idx;
    logic [DESC_TAG_NBITS-1:0] tag;
    logic [CTX_BYTE_NBITS-1:0] ctx_byte;
    port_id_t                  port_id;
    logic                      emit_now;

    assign emit_now = (state == EMIT) && !pu_em_data_valid_in;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:    if (piarb_pu_valid && piarb_pu_pid == PU_ID) state <= REQ_CTX;
                REQ_CTX: if (io.io_ack) state <= REQ_SW;
                REQ_SW:  if (io.io_ack) state <= EMIT;
                EMIT:    if (emit_now) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && piarb_pu_valid && piarb_pu_pid == PU_ID) begin
            flow_idx <= piarb_pu_data[TBL_DEPTH_NBITS-1:0];
            tag      <= piarb_pu_data[DATA_NBITS-1:DESC_TAG_LSB];
        end
        if (state == REQ_CTX && io.io_ack) begin
            ctx_byte <= io.io_ack_data[CTX_BYTE_NBITS-1:0];
        end
        if (state == REQ_SW && io.io_ack) begin
            port_id <= io.io_ack_data[PORT_ID_NBITS-1:0];
        end
    end

    assign io.io_req  = (state == REQ_CTX) || (state == REQ_SW);
    assign io.io_sel  = (state == REQ_SW) ? TBL_SWITCH_INFO : TBL_CONN_CONTEXT;
    assign io.io_addr = flow_idx;

    // Upstream traffic on the chain always has priority over the own word.
    assign pu_em_data_valid_out  = pu_em_data_valid_in | emit_now;
    assign pu_em_port_id_out     = pu_em_data_valid_in ? pu_em_port_id_in : port_id;
    assign pu_em_packet_data_out = pu_em_data_valid_in ? pu_em_packet_data_in
                                                       : {tag, ctx_byte};
    assign pu_id_out             = pu_em_data_valid_in ? pu_id_in : PU_ID;

endmodule

/* source/pu_io_arb.sv */
/*
 * Round-robin arbiter between the cores and the two tables.
 * One grant per cycle, the ack and read data follow one cycle later.
 */
module pu_io_arb import pu_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    pu_io_if.arb      core_io [NUM_OF_PU],
    output logic      mem_rd_ctx,
    output logic      mem_rd_sw,
    output tbl_idx_t  mem_addr,
    input  tbl_word_t ctx_rdata,
    input  tbl_word_t sw_rdata
);

    logic [NUM_OF_PU-1:0] req;
    tbl_sel_t             req_sel  [NUM_OF_PU];
    tbl_idx_t             req_addr [NUM_OF_PU];
    logic                 gnt_vld;
    pu_id_t               gnt_id;
    pu_id_t               rr_ptr;
    logic                 ack_vld;
    pu_id_t               ack_id;
    tbl_sel_t             ack_sel;
    tbl_word_t            ack_data;

    for (genvar k = 0; k < NUM_OF_PU; k++) begin : g_core
        assign req[k]                 = core_io[k].io_req;
        assign req_sel[k]             = core_io[k].io_sel;
        assign req_addr[k]            = core_io[k].io_addr;
        assign core_io[k].io_ack      = ack_vld && (ack_id == pu_id_t'(k));
        assign core_io[k].io_ack_data = ack_data;
    end

    // First requester at or after the pointer wins, skipping a pending ack.
    always_comb begin
        pu_id_t idx;
        gnt_vld = 1'b0;
        gnt_id  = rr_ptr;
        for (int i = 0; i < NUM_OF_PU; i++) begin
            idx = pu_id_t'((int'(rr_ptr) + i) % NUM_OF_PU);
            if (!gnt_vld && req[idx] && !(ack_vld && ack_id == idx)) begin
                gnt_vld = 1'b1;
                gnt_id  = idx;
            end
        end
    end

    assign mem_rd_ctx = gnt_vld && (req_sel[gnt_id] == TBL_CONN_CONTEXT);
    assign mem_rd_sw  = gnt_vld && (req_sel[gnt_id] == TBL_SWITCH_INFO);
    assign mem_addr   = req_addr[gnt_id];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rr_ptr  <= '0;
            ack_vld <= 1'b0;
            ack_id  <= '0;
            ack_sel <= '0;
        end else begin
            ack_vld <= gnt_vld;
            if (gnt_vld) begin
                ack_id  <= gnt_id;
                ack_sel <= req_sel[gnt_id];
                rr_ptr  <= (gnt_id == pu_id_t'(NUM_OF_PU - 1)) ? '0 : gnt_id + 1'b1;
            end
        end
    end

    always_comb begin
        case (ack_sel)
            TBL_CONN_CONTEXT: ack_data = ctx_rdata;
            TBL_SWITCH_INFO:  ack_data = sw_rdata;
            default:          ack_data = '0;
        endcase
    end

endmodule

/* source/pu_table_mem.sv */
/*
 * 64-entry lookup table with a PIO read/write port and a second read port
 * for the table-access arbiter. Both reads are registered, one cycle.
 * A write and a read of the same entry in one cycle return the old value.
 */
module pu_table_mem import pu_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      reg_ms,
    input  logic      reg_wr,
    input  logic      reg_rd,
    input  tbl_idx_t  reg_addr,
    input  tbl_word_t reg_din,
    output tbl_word_t reg_rdata,
    input  logic      mem_rd,
    input  tbl_idx_t  mem_addr,
    output tbl_word_t mem_rdata
);

    tbl_word_t mem [TBL_DEPTH];

    always_ff @(posedge clk) begin
        if (reg_ms && reg_wr) begin
            mem[reg_addr] <= reg_din;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            reg_rdata <= '0;
            mem_rdata <= '0;
        end else begin
            if (reg_ms && reg_rd) begin
                reg_rdata <= mem[reg_addr];
            end
            if (mem_rd) begin
                mem_rdata <= mem[mem_addr];
            end
        end
    end

endmodule

/* source/pu_pio.sv */
/*
 * PIO decoder of the cluster.
 * Turns the start/address/data beats into table strobes and returns
 * pio_ack for writes and pio_rvalid with read data two cycles after start.
 */
module pu_pio import pu_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      pio_start,
    input  logic      pio_rw,
    input  pio_word_t pio_addr_wdata,
    output logic      reg_wr,
    output logic      reg_rd,
    output tbl_idx_t  reg_addr,
    output tbl_word_t reg_din,
    output logic      reg_ms_conn_context,
    output logic      reg_ms_switch_info,
    input  tbl_word_t conn_context_rdata,
    input  tbl_word_t switch_info_rdata,
    output logic      pio_ack,
    output logic      pio_rvalid,
    output pio_word_t pio_rdata
);

    tbl_sel_t sel_q;
    logic     wait_data;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sel_q      <= '0;
            reg_addr   <= '0;
            wait_data  <= 1'b0;
            reg_rd     <= 1'b0;
            reg_wr     <= 1'b0;
            pio_ack    <= 1'b0;
            pio_rvalid <= 1'b0;
        end else begin
            if (pio_start) begin
                sel_q    <= pio_addr_wdata[TBL_SEL_LSB +: TBL_SEL_NBITS];
                reg_addr <= pio_addr_wdata[TBL_DEPTH_NBITS-1:0];
            end
            wait_data  <= pio_start & ~pio_rw;  // Data beat follows next cycle.
            reg_rd     <= pio_start & pio_rw;
            reg_wr     <= wait_data;
            pio_ack    <= wait_data;
            pio_rvalid <= reg_rd;  // Table answers one cycle after reg_rd.
        end
    end

    always_ff @(posedge clk) begin
        if (wait_data) begin
            reg_din <= pio_addr_wdata;
        end
    end

    assign reg_ms_conn_context = (sel_q == TBL_CONN_CONTEXT);
    assign reg_ms_switch_info  = (sel_q == TBL_SWITCH_INFO);

    always_comb begin
        case (sel_q)
            TBL_CONN_CONTEXT: pio_rdata = conn_context_rdata;
            TBL_SWITCH_INFO:  pio_rdata = switch_info_rdata;
            default:          pio_rdata = '0;  // Unmapped selects read as zero.
        endcase
    end

endmodule

/* source/pu_io_if.sv */
/*
 * Table-access channel of one core.
 * The core holds its request until a one-cycle ack with the read data.
 */
interface pu_io_if import pu_pkg::*; ();

    logic      io_req;
    tbl_sel_t  io_sel;
    tbl_idx_t  io_addr;
    logic      io_ack;
    tbl_word_t io_ack_data;

    modport core (
        output io_req, io_sel, io_addr,
        input  io_ack, io_ack_data
    );

    modport arb (
        input  io_req, io_sel, io_addr,
        output io_ack, io_ack_data
    );

endinterface

/* source/pu_pkg.sv */
/*
 * Shared definitions of the processing-unit cluster.
 * Holds the widths, the PIO table address map, the typedefs and the core
 * state encoding. Modules pull it in with a wildcard import in their header.
 */
package pu_pkg;

    localparam int NUM_OF_PU       = 2;
    localparam int PIO_NBITS       = 32;
    localparam int DATA_NBITS      = 32;
    localparam int TBL_DEPTH_NBITS = 6;
    localparam int TBL_DEPTH       = 1 << TBL_DEPTH_NBITS;
    localparam int TBL_WORD_NBITS  = 32;
    localparam int PU_ID_NBITS     = 1;
    localparam int PORT_ID_NBITS   = 4;
    localparam int TBL_SEL_NBITS   = 2;

    // PIO address bits 9:8 pick the table, bits 5:0 the entry.
    localparam int TBL_SEL_LSB = 8;

    // Descriptor layout, the flow index sits in the low bits.
    localparam int DESC_TAG_LSB   = 8;
    localparam int DESC_TAG_NBITS = DATA_NBITS - DESC_TAG_LSB;
    localparam int CTX_BYTE_NBITS = 8;

    typedef logic [PIO_NBITS-1:0]       pio_word_t;
    typedef logic [TBL_DEPTH_NBITS-1:0] tbl_idx_t;
    typedef logic [TBL_WORD_NBITS-1:0]  tbl_word_t;
    typedef logic [PU_ID_NBITS-1:0]     pu_id_t;
    typedef logic [PORT_ID_NBITS-1:0]   port_id_t;
    typedef logic [TBL_SEL_NBITS-1:0]   tbl_sel_t;

    localparam tbl_sel_t TBL_CONN_CONTEXT = 2'd0;
    localparam tbl_sel_t TBL_SWITCH_INFO  = 2'd1;

    typedef enum logic [1:0] {
        IDLE,
        REQ_CTX,
        REQ_SW,
        EMIT
    } core_state_t;

endpackage
